//--- src/spu_pkg.sv
package spu_pkg;

  // datapath widths
  localparam int DATA_W = 128;
  localparam int REG_AW = 7;
  localparam int REG_COUNT = 128;

  // instruction fields carried through the stage
  localparam int ID_W = 7;
  localparam int PC_W = 9;

  // each pipe has its own no-op encoding
  localparam logic [ID_W-1:0] NOP_EVEN = 7'd86;
  localparam logic [ID_W-1:0] NOP_ODD = 7'd85;

endpackage

//--- src/fwd_pkg.sv
package fwd_pkg;

  // in-flight results sit in stages 2..7 of each pipe
  localparam int FWD_FIRST = 2;
  localparam int FWD_DEPTH = 6;

  // slot 2k is even pipe stage FWD_FIRST+k, slot 2k+1 the odd pipe
  localparam int FWD_SLOTS = 2 * FWD_DEPTH;

  // ra, rb, rc even then ra, rb, rc odd
  localparam int NUM_SRC = 6;

  // select code is a slot index, one past the last slot means register file
  localparam int SEL_W = 4;
  localparam logic [SEL_W-1:0] SEL_RF = 4'd12;

endpackage

//--- src/fwd_bus_if.sv
`timescale 1ns/1ps

interface fwd_bus_if;

  // stage-major, even before odd within a stage
  logic [fwd_pkg::FWD_SLOTS-1:0][spu_pkg::DATA_W-1:0] result;
  logic [fwd_pkg::FWD_SLOTS-1:0][spu_pkg::REG_AW-1:0] dst;
  logic [fwd_pkg::FWD_SLOTS-1:0] wr;

  // hazard compare only needs destination and write flag
  modport hazard (
    input dst,
    input wr
  );

  // operand mux only needs the payload
  modport data (
    input result
  );

endinterface

//--- src/spu_regfile.sv
`timescale 1ns/1ps

module spu_regfile (
  input  logic clk,
  input  logic rst,
  input  logic write_en_1,
  input  logic write_en_2,
  input  logic [spu_pkg::REG_AW-1:0] write_addr_1,
  input  logic [spu_pkg::REG_AW-1:0] write_addr_2,
  input  logic [spu_pkg::DATA_W-1:0] write_data_1,
  input  logic [spu_pkg::DATA_W-1:0] write_data_2,
  input  logic [fwd_pkg::NUM_SRC-1:0][spu_pkg::REG_AW-1:0] read_addr,
  output logic [fwd_pkg::NUM_SRC-1:0][spu_pkg::DATA_W-1:0] read_data
);

  logic [spu_pkg::DATA_W-1:0] regs [spu_pkg::REG_COUNT];

  // no writes while in reset
  // port 2 is written last so it wins on the same address
  always_ff @(posedge clk) begin
    if (!rst) begin
      if (write_en_1) begin
        regs[write_addr_1] <= write_data_1;
      end
      if (write_en_2) begin
        regs[write_addr_2] <= write_data_2;
      end
    end
  end

  // six async read ports, no bypass from the write ports
  always_comb begin
    for (int i = 0; i < fwd_pkg::NUM_SRC; i++) begin
      read_data[i] = regs[read_addr[i]];
    end
  end

endmodule

//--- src/fwd_select.sv
`timescale 1ns/1ps

module fwd_select (
  input  logic [fwd_pkg::NUM_SRC-1:0][spu_pkg::REG_AW-1:0] src_addr,
  fwd_bus_if.hazard fwd,
  output logic [fwd_pkg::NUM_SRC-1:0][fwd_pkg::SEL_W-1:0] sel
);

  logic [fwd_pkg::NUM_SRC-1:0][fwd_pkg::FWD_SLOTS-1:0] hit;

  // every operand against every in-flight slot
  always_comb begin
    for (int i = 0; i < fwd_pkg::NUM_SRC; i++) begin
      for (int s = 0; s < fwd_pkg::FWD_SLOTS; s++) begin
        hit[i][s] = fwd.wr[s] && (fwd.dst[s] == src_addr[i]);
      end
    end
  end

  // walk from the farthest stage inward, so the nearest hit is assigned last
  // own pipe is checked after the other pipe in each stage and wins a tie
  always_comb begin
    int own_off;
    int own_slot;
    int oth_slot;
    own_off = 0;
    own_slot = 0;
    oth_slot = 0;
    for (int i = 0; i < fwd_pkg::NUM_SRC; i++) begin
      // upper half of the operands belongs to the odd pipe
      own_off = (i >= fwd_pkg::NUM_SRC / 2) ? 1 : 0;
      sel[i] = fwd_pkg::SEL_RF;
      for (int k = fwd_pkg::FWD_DEPTH - 1; k >= 0; k--) begin
        own_slot = 2 * k + own_off;
        oth_slot = 2 * k + 1 - own_off;
        if (hit[i][oth_slot]) begin
          sel[i] = fwd_pkg::SEL_W'(oth_slot);
        end
        if (hit[i][own_slot]) begin
          sel[i] = fwd_pkg::SEL_W'(own_slot);
        end
      end
    end
  end

endmodule

//--- src/operand_stage.sv
`timescale 1ns/1ps

module operand_stage (
  input  logic clk,
  input  logic rst,
  input  logic flush,
  input  logic [fwd_pkg::NUM_SRC-1:0][fwd_pkg::SEL_W-1:0] sel,
  input  logic [fwd_pkg::NUM_SRC-1:0][spu_pkg::DATA_W-1:0] rf_data,
  fwd_bus_if.data fwd,
  input  logic [spu_pkg::ID_W-1:0] instr_id_even,
  input  logic [spu_pkg::ID_W-1:0] instr_id_odd,
  input  logic [spu_pkg::REG_AW-1:0] reg_dst_even,
  input  logic [spu_pkg::REG_AW-1:0] reg_dst_odd,
  input  logic reg_wr_even,
  input  logic reg_wr_odd,
  input  logic [spu_pkg::PC_W-1:0] pc_in,
  input  logic branch_in,
  output logic [fwd_pkg::NUM_SRC-1:0][spu_pkg::DATA_W-1:0] operand,
  output logic [spu_pkg::ID_W-1:0] out_instr_id_even,
  output logic [spu_pkg::ID_W-1:0] out_instr_id_odd,
  output logic [spu_pkg::REG_AW-1:0] out_reg_dst_even,
  output logic [spu_pkg::REG_AW-1:0] out_reg_dst_odd,
  output logic out_reg_wr_even,
  output logic out_reg_wr_odd,
  output logic [spu_pkg::PC_W-1:0] pc_out,
  output logic branch_out
);

  logic [fwd_pkg::NUM_SRC-1:0][spu_pkg::DATA_W-1:0] operand_d;

  // forwarded slot or register file value
  always_comb begin
    for (int i = 0; i < fwd_pkg::NUM_SRC; i++) begin
      if (sel[i] < fwd_pkg::SEL_RF) begin
        operand_d[i] = fwd.result[sel[i]];
      end else begin
        operand_d[i] = rf_data[i];
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      operand <= '0;
      out_instr_id_even <= '0;
      out_instr_id_odd <= '0;
      out_reg_dst_even <= '0;
      out_reg_dst_odd <= '0;
      out_reg_wr_even <= 1'b0;
      out_reg_wr_odd <= 1'b0;
      pc_out <= '0;
      branch_out <= 1'b0;
    end else begin
      if (flush) begin
        // both slots turn into their pipe's no-op
        operand <= '0;
        out_instr_id_even <= spu_pkg::NOP_EVEN;
        out_instr_id_odd <= spu_pkg::NOP_ODD;
        out_reg_dst_even <= '0;
        out_reg_dst_odd <= '0;
        out_reg_wr_even <= 1'b0;
        out_reg_wr_odd <= 1'b0;
      end else begin
        operand <= operand_d;
        out_instr_id_even <= instr_id_even;
        out_instr_id_odd <= instr_id_odd;
        out_reg_dst_even <= reg_dst_even;
        out_reg_dst_odd <= reg_dst_odd;
        out_reg_wr_even <= reg_wr_even;
        out_reg_wr_odd <= reg_wr_odd;
      end
      // pc and branch flag are not affected by flush
      pc_out <= pc_in;
      branch_out <= branch_in;
    end
  end

endmodule

//--- src/rf_fetch_top.sv
`timescale 1ns/1ps

module rf_fetch_top (
  input  logic clk,
  input  logic rst,
  input  logic flush,
  input  logic [spu_pkg::PC_W-1:0] pc_in,
  input  logic branch_in,
  input  logic [spu_pkg::ID_W-1:0] instr_id_even,
  input  logic [spu_pkg::ID_W-1:0] instr_id_odd,
  input  logic [spu_pkg::REG_AW-1:0] reg_dst_even,
  input  logic [spu_pkg::REG_AW-1:0] reg_dst_odd,
  input  logic reg_wr_even,
  input  logic reg_wr_odd,
  input  logic [fwd_pkg::NUM_SRC-1:0][spu_pkg::REG_AW-1:0] src_addr,
  input  logic write_en_1,
  input  logic write_en_2,
  input  logic [spu_pkg::REG_AW-1:0] write_addr_1,
  input  logic [spu_pkg::REG_AW-1:0] write_addr_2,
  input  logic [spu_pkg::DATA_W-1:0] write_data_1,
  input  logic [spu_pkg::DATA_W-1:0] write_data_2,
  input  logic [fwd_pkg::FWD_SLOTS-1:0][spu_pkg::DATA_W-1:0] fwd_result,
  input  logic [fwd_pkg::FWD_SLOTS-1:0][spu_pkg::REG_AW-1:0] fwd_dst,
  input  logic [fwd_pkg::FWD_SLOTS-1:0] fwd_wr,
  output logic [fwd_pkg::NUM_SRC-1:0][spu_pkg::DATA_W-1:0] operand,
  output logic [spu_pkg::ID_W-1:0] out_instr_id_even,
  output logic [spu_pkg::ID_W-1:0] out_instr_id_odd,
  output logic [spu_pkg::REG_AW-1:0] out_reg_dst_even,
  output logic [spu_pkg::REG_AW-1:0] out_reg_dst_odd,
  output logic out_reg_wr_even,
  output logic out_reg_wr_odd,
  output logic [spu_pkg::PC_W-1:0] pc_out,
  output logic branch_out
);

  logic [fwd_pkg::NUM_SRC-1:0][spu_pkg::DATA_W-1:0] rf_data;
  logic [fwd_pkg::NUM_SRC-1:0][fwd_pkg::SEL_W-1:0] sel;

  // in-flight results from later stages of both pipes
  fwd_bus_if fwd_bus ();

  assign fwd_bus.result = fwd_result;
  assign fwd_bus.dst = fwd_dst;
  assign fwd_bus.wr = fwd_wr;

  spu_regfile u_regfile (
    .clk          (clk),
    .rst          (rst),
    .write_en_1   (write_en_1),
    .write_en_2   (write_en_2),
    .write_addr_1 (write_addr_1),
    .write_addr_2 (write_addr_2),
    .write_data_1 (write_data_1),
    .write_data_2 (write_data_2),
    .read_addr    (src_addr),
    .read_data    (rf_data)
  );

  fwd_select u_fwd_select (
    .src_addr (src_addr),
    .fwd      (fwd_bus.hazard),
    .sel      (sel)
  );

  operand_stage u_operand_stage (
    .clk               (clk),
    .rst               (rst),
    .flush             (flush),
    .sel               (sel),
    .rf_data           (rf_data),
    .fwd               (fwd_bus.data),
    .instr_id_even     (instr_id_even),
    .instr_id_odd      (instr_id_odd),
    .reg_dst_even      (reg_dst_even),
    .reg_dst_odd       (reg_dst_odd),
    .reg_wr_even       (reg_wr_even),
    .reg_wr_odd        (reg_wr_odd),
    .pc_in             (pc_in),
    .branch_in         (branch_in),
    .operand           (operand),
    .out_instr_id_even (out_instr_id_even),
    .out_instr_id_odd  (out_instr_id_odd),
    .out_reg_dst_even  (out_reg_dst_even),
    .out_reg_dst_odd   (out_reg_dst_odd),
    .out_reg_wr_even   (out_reg_wr_even),
    .out_reg_wr_odd    (out_reg_wr_odd),
    .pc_out            (pc_out),
    .branch_out        (branch_out)
  );

endmodule

//--- verif/rf_fetch_props.sv
`timescale 1ns/1ps

module rf_fetch_props (
  input logic clk,
  input logic rst,
  input logic flush,
  input logic [fwd_pkg::NUM_SRC-1:0][fwd_pkg::SEL_W-1:0] sel,
  input logic [fwd_pkg::NUM_SRC-1:0][spu_pkg::DATA_W-1:0] operand,
  input logic [spu_pkg::ID_W-1:0] out_instr_id_even,
  input logic [spu_pkg::ID_W-1:0] out_instr_id_odd,
  input logic [spu_pkg::REG_AW-1:0] out_reg_dst_even,
  input logic [spu_pkg::REG_AW-1:0] out_reg_dst_odd,
  input logic out_reg_wr_even,
  input logic out_reg_wr_odd,
  input logic [spu_pkg::PC_W-1:0] pc_out,
  input logic branch_out
);

  int flush_fails = 0;
  int reset_fails = 0;
  int sel_fails = 0;
  logic sel_ok;

  // each code is a slot index or the register file code
  always_comb begin
    sel_ok = 1'b1;
    for (int i = 0; i < fwd_pkg::NUM_SRC; i++) begin
      if (sel[i] > fwd_pkg::SEL_RF) begin
        sel_ok = 1'b0;
      end
    end
  end

  flush_nop: assert property (@(posedge clk) disable iff (rst)
    flush |=> (!out_reg_wr_even && !out_reg_wr_odd && out_instr_id_even == spu_pkg::NOP_EVEN
               && out_instr_id_odd == spu_pkg::NOP_ODD))
    else begin
      $error("flush did not turn both slots into no-ops");
      flush_fails++;
    end

  // a full cycle of reset has cleared every register
  reset_zero: assert property (@(posedge clk)
    $past(rst) && rst |-> ({operand, out_instr_id_even, out_instr_id_odd, out_reg_dst_even,
                            out_reg_dst_odd, out_reg_wr_even, out_reg_wr_odd, pc_out,
                            branch_out} == '0))
    else begin
      $error("outputs not cleared during reset");
      reset_fails++;
    end

  sel_range: assert property (@(posedge clk) disable iff (rst) sel_ok)
    else begin
      $error("a select code is past the register file code");
      sel_fails++;
    end

endmodule

//--- verif/rf_fetch_checker.sv
`timescale 1ns/1ps

module rf_fetch_checker (
  input logic clk, rst, flush, branch_in, reg_wr_even, reg_wr_odd,
  input logic write_en_1, write_en_2, out_reg_wr_even, out_reg_wr_odd, branch_out,
  input logic [2:0] test_id,
  input logic [spu_pkg::PC_W-1:0] pc_in, pc_out,
  input logic [spu_pkg::ID_W-1:0] instr_id_even, instr_id_odd,
  input logic [spu_pkg::ID_W-1:0] out_instr_id_even, out_instr_id_odd,
  input logic [spu_pkg::REG_AW-1:0] reg_dst_even, reg_dst_odd, out_reg_dst_even, out_reg_dst_odd,
  input logic [spu_pkg::REG_AW-1:0] write_addr_1, write_addr_2,
  input logic [spu_pkg::DATA_W-1:0] write_data_1, write_data_2,
  input logic [fwd_pkg::NUM_SRC-1:0][spu_pkg::REG_AW-1:0] src_addr,
  input logic [fwd_pkg::FWD_SLOTS-1:0][spu_pkg::DATA_W-1:0] fwd_result,
  input logic [fwd_pkg::FWD_SLOTS-1:0][spu_pkg::REG_AW-1:0] fwd_dst,
  input logic [fwd_pkg::FWD_SLOTS-1:0] fwd_wr,
  input logic [fwd_pkg::NUM_SRC-1:0][spu_pkg::DATA_W-1:0] operand
);

  string names [6] = '{"reset", "rf_read", "fwd_stage", "fwd_cross", "flush", "random"};
  logic [spu_pkg::DATA_W-1:0] shadow [spu_pkg::REG_COUNT];
  logic [fwd_pkg::NUM_SRC-1:0][spu_pkg::DATA_W-1:0] exp_operand;
  logic [39:0] exp_fields;
  logic [39:0] act_fields;
  logic [2:0] exp_test;
  logic have_exp = 1'b0;
  int operand_errs = 0;
  int field_errs = 0;

  assign act_fields = {out_instr_id_even, out_instr_id_odd, out_reg_dst_even, out_reg_dst_odd,
                       out_reg_wr_even, out_reg_wr_odd, pc_out, branch_out};

  // nearest stage first, own pipe ahead of the other one
  function automatic logic [spu_pkg::DATA_W-1:0] ref_operand(
      input logic odd, input logic [spu_pkg::REG_AW-1:0] addr);
    logic [3:0] slot;
    for (int k = 0; k < fwd_pkg::FWD_DEPTH; k++) begin
      for (int p = 0; p < 2; p++) begin
        slot = 4'(2 * k) + {3'd0, odd ^ (p == 1)};
        if (fwd_wr[slot] && fwd_dst[slot] == addr) begin
          return fwd_result[slot];
        end
      end
    end
    return shadow[addr];
  endfunction

  // expectation from the inputs of this edge, register file as it was before it
  always @(posedge clk) begin
    have_exp = 1'b1;
    exp_test = test_id;
    if (rst) begin
      exp_operand = '0;
      exp_fields = '0;
    end else begin
      for (int i = 0; i < fwd_pkg::NUM_SRC; i++) begin
        exp_operand[i] = flush ? '0 : ref_operand(i >= fwd_pkg::NUM_SRC / 2, src_addr[i]);
      end
      if (flush) begin
        exp_fields = {spu_pkg::NOP_EVEN, spu_pkg::NOP_ODD, 16'd0, pc_in, branch_in};
      end else begin
        exp_fields = {instr_id_even, instr_id_odd, reg_dst_even, reg_dst_odd,
                      reg_wr_even, reg_wr_odd, pc_in, branch_in};
      end
      // port 2 lands last on a shared address
      if (write_en_1) begin
        shadow[write_addr_1] = write_data_1;
      end
      if (write_en_2) begin
        shadow[write_addr_2] = write_data_2;
      end
    end
  end

  always @(negedge clk) begin
    if (have_exp) begin
      for (int i = 0; i < fwd_pkg::NUM_SRC; i++) begin
        if (operand[i] !== exp_operand[i]) begin
          operand_errs++;
          $display("ERR %s operand %0d expected %h actual %h", names[exp_test], i,
                   exp_operand[i], operand[i]);
        end
      end
      if (act_fields !== exp_fields) begin
        field_errs++;
        $display("ERR %s fields expected %h actual %h", names[exp_test], exp_fields, act_fields);
      end
    end
  end

endmodule

//--- verif/tb_rf_fetch.sv
`timescale 1ns/1ps

module tb_rf_fetch;

  localparam int FILL_CYCLES = spu_pkg::REG_COUNT / 2;
  localparam int RAND_CYCLES = 200;
  // reset, fill, reads, double write, forwarding masks, flush, random, drain
  localparam int TEST_CYCLES = 2 + FILL_CYCLES + 8 + 2 + 6 + 2 + RAND_CYCLES + 3;
  localparam int CYCLE_LIMIT = TEST_CYCLES + 50;

  logic clk = 1'b0;
  logic rst, flush, branch_in, reg_wr_even, reg_wr_odd, write_en_1, write_en_2;
  logic out_reg_wr_even, out_reg_wr_odd, branch_out;
  logic [2:0] test_id;
  logic [spu_pkg::PC_W-1:0] pc_in, pc_out;
  logic [spu_pkg::ID_W-1:0] instr_id_even, instr_id_odd, out_instr_id_even, out_instr_id_odd;
  logic [spu_pkg::REG_AW-1:0] reg_dst_even, reg_dst_odd, out_reg_dst_even, out_reg_dst_odd;
  logic [spu_pkg::REG_AW-1:0] write_addr_1, write_addr_2;
  logic [spu_pkg::DATA_W-1:0] write_data_1, write_data_2;
  logic [fwd_pkg::NUM_SRC-1:0][spu_pkg::REG_AW-1:0] src_addr;
  logic [fwd_pkg::NUM_SRC-1:0][spu_pkg::DATA_W-1:0] operand;
  logic [fwd_pkg::FWD_SLOTS-1:0][spu_pkg::DATA_W-1:0] fwd_result;
  logic [fwd_pkg::FWD_SLOTS-1:0][spu_pkg::REG_AW-1:0] fwd_dst;
  logic [fwd_pkg::FWD_SLOTS-1:0] fwd_wr;
  logic [31:0] rng = 32'h5b57;
  int cycles = 0;

  rf_fetch_top UUT (.*);
  rf_fetch_checker chk (.*);
  bind operand_stage rf_fetch_props props (.*);

  initial begin
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display(">>> FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [spu_pkg::DATA_W-1:0] next_data();
    logic [spu_pkg::DATA_W-1:0] d;
    for (int w = 0; w < spu_pkg::DATA_W / 32; w++) begin
      rng = xorshift(rng);
      d[32 * w +: 32] = rng;
    end
    return d;
  endfunction

  task automatic idle_inputs();
    {flush, branch_in, reg_wr_even, reg_wr_odd, write_en_1, write_en_2} = '0;
    {pc_in, instr_id_even, instr_id_odd, reg_dst_even, reg_dst_odd} = '0;
    {write_addr_1, write_addr_2, write_data_1, write_data_2, src_addr} = '0;
    {fwd_result, fwd_dst, fwd_wr} = '0;
  endtask

  // small address range so sources and in-flight results collide often
  task automatic random_inputs();
    rng = xorshift(rng);
    {pc_in, instr_id_even, instr_id_odd, reg_dst_even} = rng[29:0];
    rng = xorshift(rng);
    {reg_dst_odd, branch_in, reg_wr_even, reg_wr_odd, write_en_1, write_en_2} = rng[11:0];
    fwd_wr = rng[23:12];
    write_addr_1 = {4'd0, rng[26:24]};
    write_addr_2 = {4'd0, rng[29:27]};
    flush = (rng[31:30] == 2'b11);
    write_data_1 = next_data();
    write_data_2 = next_data();
    for (int i = 0; i < fwd_pkg::NUM_SRC; i++) begin
      rng = xorshift(rng);
      src_addr[i] = {4'd0, rng[2:0]};
    end
    for (int s = 0; s < fwd_pkg::FWD_SLOTS; s++) begin
      rng = xorshift(rng);
      fwd_dst[s] = {4'd0, rng[2:0]};
      fwd_result[s] = next_data();
    end
  endtask

  initial begin
    logic [fwd_pkg::FWD_SLOTS-1:0] masks [6];
    int assert_fails;
    masks = '{12'h0c3, 12'h0c0, 12'h048, 12'h030, 12'h002, 12'h804};
    rst = 1'b1;
    test_id = 3'd0;
    idle_inputs();
    repeat (2) @(negedge clk);
    rst = 1'b0;
    // fill with flush held so no operand reads an unwritten register
    test_id = 3'd1;
    flush = 1'b1;
    write_en_1 = 1'b1;
    write_en_2 = 1'b1;
    for (int a = 0; a < FILL_CYCLES; a++) begin
      write_addr_1 = spu_pkg::REG_AW'(2 * a);
      write_addr_2 = spu_pkg::REG_AW'(2 * a + 1);
      write_data_1 = next_data();
      write_data_2 = next_data();
      @(negedge clk);
    end
    idle_inputs();
    for (int n = 0; n < 8; n++) begin
      for (int i = 0; i < fwd_pkg::NUM_SRC; i++) begin
        rng = xorshift(rng);
        src_addr[i] = rng[6:0];
      end
      @(negedge clk);
    end
    // both write ports on one address
    write_en_1 = 1'b1;
    write_en_2 = 1'b1;
    write_addr_1 = 7'd5;
    write_addr_2 = 7'd5;
    write_data_1 = next_data();
    write_data_2 = next_data();
    @(negedge clk);
    idle_inputs();
    src_addr = {fwd_pkg::NUM_SRC{7'd5}};
    @(negedge clk);
    // every slot holds the source register, the wr mask decides which are live
    src_addr = {fwd_pkg::NUM_SRC{7'd10}};
    fwd_dst = {fwd_pkg::FWD_SLOTS{7'd10}};
    for (int m = 0; m < 6; m++) begin
      test_id = (m < 2) ? 3'd2 : 3'd3;
      fwd_wr = masks[m];
      for (int s = 0; s < fwd_pkg::FWD_SLOTS; s++) begin
        fwd_result[s] = next_data();
      end
      @(negedge clk);
    end
    test_id = 3'd4;
    for (int n = 0; n < 2; n++) begin
      random_inputs();
      flush = 1'b1;
      @(negedge clk);
    end
    test_id = 3'd5;
    for (int n = 0; n < RAND_CYCLES; n++) begin
      random_inputs();
      @(negedge clk);
    end
    idle_inputs();
    repeat (2) @(negedge clk);
    @(posedge clk);
    assert_fails = UUT.u_operand_stage.props.flush_fails
                 + UUT.u_operand_stage.props.reset_fails
                 + UUT.u_operand_stage.props.sel_fails;
    $display("checks done: %0d operand errors, %0d field errors, %0d assertion failures",
             chk.operand_errs, chk.field_errs, assert_fails);
    if (chk.operand_errs + chk.field_errs + assert_fails == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- src.f
src/spu_pkg.sv
src/fwd_pkg.sv
src/fwd_bus_if.sv
src/spu_regfile.sv
src/fwd_select.sv
src/operand_stage.sv
src/rf_fetch_top.sv
verif/rf_fetch_props.sv
verif/rf_fetch_checker.sv
verif/tb_rf_fetch.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_rf_fetch
LINT_TOP  = rf_fetch_top
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q ">>> PASS" $(LOG) && echo "simulation passed" || (echo "simulation failed"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
